//--- compile.f
+incdir+verification
hw/lsu_pkg.sv
hw/operand_queue.sv
hw/load_station.sv
hw/store_station.sv
hw/mem_issue.sv
hw/load_store_unit.sv
verification/tb_load_store_unit.sv

//--- Bender.yml
package:
  name: load_store_unit

sources:
  - hw/lsu_pkg.sv
  - hw/operand_queue.sv
  - hw/load_station.sv
  - hw/store_station.sv
  - hw/mem_issue.sv
  - hw/load_store_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_load_store_unit.sv

//--- verification/lsu_model.svh
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

// one expected memory request in program order per queue
typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  mask;
    logic [31:0] wdata;
    logic [15:0] age;
    logic [4:0]  rob_id;
    logic        waiting;
    logic [4:0]  wait_tag;
} exp_op_t;

// a result broadcast scheduled for a later cycle
typedef struct packed {
    logic [4:0]  tag;
    logic [31:0] value;
    logic [7:0]  delay;
} bcast_t;

exp_op_t exp_loads[$];
exp_op_t exp_stores[$];
bcast_t  pending[$];

// size follows funct3[1:0] with 0 for byte, 1 for half and 2 for word
function automatic logic [3:0] expect_mask(input logic [1:0] size, input logic [1:0] lo);
    logic [3:0] m;
    m = 4'b0000;
    case (size)
        2'd0: m[lo] = 1'b1;
        2'd1: begin
            m[lo]        = 1'b1;
            m[lo + 2'd1] = 1'b1;
        end
        default: m = 4'b1111;
    endcase
    return m;
endfunction

function automatic logic [31:0] expect_wdata(input logic [1:0] size, input logic [1:0] lo,
                                             input logic [31:0] rs2);
    logic [31:0] rep;
    logic [3:0]  m;
    case (size)
        2'd0:    rep = {4{rs2[7:0]}};
        2'd1:    rep = {2{rs2[15:0]}};
        default: rep = rs2;
    endcase
    m = expect_mask(size, lo);
    return rep & {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
endfunction

// an unsent store older than the load that writes the same word
function automatic bit older_store_same_word(input logic [31:0] waddr, input logic [15:0] age);
    foreach (exp_stores[i]) begin
        if (exp_stores[i].age < age && exp_stores[i].addr == waddr) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

`endif

//--- verification/tb_load_store_unit.sv
`timescale 1ns/1ps

module tb_load_store_unit;

    logic                  clk;
    logic                  rst;
    lsu_pkg::ls_dispatch_t dispatch;
    lsu_pkg::cdb_t         cdb;
    logic [4:0]            rob_head;
    lsu_pkg::mem_state_e   mem_state;
    logic                  branch_mispredict;
    logic                  load_full;
    logic                  store_full;
    lsu_pkg::dmem_req_t    dmem;

    `include "lsu_model.svh"

    int          seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          err_mark;
    logic [15:0] next_age;
    logic [4:0]  next_rob;
    logic [4:0]  next_tag;
    bit          disp_last;
    bit          saw_load_full;
    bit          saw_store_full;
    int          flush_check_wait;

    load_store_unit #(.load_depth(8), .store_depth(8), .tag_w(5)) dut0 (
        .clk(clk), .rst(rst), .dispatch(dispatch), .cdb(cdb), .rob_head(rob_head),
        .mem_state(mem_state), .branch_mispredict(branch_mispredict),
        .load_full(load_full), .store_full(store_full), .dmem(dmem)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("failure: %s", msg);
    endtask

    task automatic check_request();
        exp_op_t e;
        if ((dmem.wmask != 0 || dmem.rmask != 0) && mem_state != lsu_pkg::mem_idle) begin
            report_failure("memory request issued while the controller was not idle");
        end
        if (dmem.wmask != 0 && dmem.rmask != 0) begin
            report_failure("read and write masks set in the same cycle");
        end
        if (dmem.wmask != 0) begin
            if (exp_stores.size() == 0) begin
                report_failure("store request appeared with no store expected");
            end else begin
                e = exp_stores.pop_front();
                check_hex("dmem.addr", dmem.addr, e.addr);
                check_hex("dmem.wmask", dmem.wmask, e.mask);
                check_hex("dmem.wdata", dmem.wdata, e.wdata);
                check_hex("rob_head", rob_head, e.rob_id);
                if (e.waiting) begin
                    report_failure("store issued before its operand was broadcast");
                end
            end
        end else if (dmem.rmask != 0) begin
            if (exp_loads.size() == 0) begin
                report_failure("load request appeared with no load expected");
            end else begin
                e = exp_loads.pop_front();
                check_hex("dmem.addr", dmem.addr, e.addr);
                check_hex("dmem.rmask", dmem.rmask, e.mask);
                if (e.waiting) begin
                    report_failure("load issued before its operand was broadcast");
                end
                if (older_store_same_word(e.addr, e.age)) begin
                    report_failure("load passed an older unsent store to the same word");
                end
            end
        end
    endtask

    task automatic clear_waiting(input logic [4:0] tag);
        foreach (exp_loads[i]) begin
            if (exp_loads[i].waiting && exp_loads[i].wait_tag == tag) exp_loads[i].waiting = 0;
        end
        foreach (exp_stores[i]) begin
            if (exp_stores[i].waiting && exp_stores[i].wait_tag == tag) exp_stores[i].waiting = 0;
        end
    endtask

    function automatic bit tag_in_use(input logic [4:0] tag);
        foreach (pending[i]) begin
            if (pending[i].tag == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic new_dispatch(input bit ld_ok, input bit st_ok,
                                output lsu_pkg::ls_dispatch_t d);
        exp_op_t     e;
        bcast_t      b;
        bit          st;
        logic [1:0]  kind;
        logic [31:0] base;
        logic [31:0] ea;
        d = '0;
        if (!ld_ok && !st_ok) return;
        st = (ld_ok && st_ok) ? bit'(rand_below(2)) : st_ok;
        if (st ? store_full : load_full) return;
        kind = 2'(rand_below(3));
        // a small window of words so that loads and stores collide
        base = 32'h100 + 32'(rand_below(8) * 4);
        d.valid     = 1'b1;
        d.is_store  = st;
        d.op        = lsu_pkg::mem_op_e'({st, !st && kind != 2 && rand_below(2) == 0, kind});
        d.imm       = 32'(rand_below(16)) & ((kind == 2) ? 32'hc : (kind == 1) ? 32'he : 32'hf);
        d.age       = next_age;
        d.rob_id    = next_rob;
        d.rs1_ready = 1'b1;
        d.rs1_value = base;
        d.rs2_ready = 1'b1;
        d.rs2_value = $random(seed);
        ea = base + d.imm;
        e.addr     = {ea[31:2], 2'b00};
        e.mask     = expect_mask(kind, ea[1:0]);
        e.wdata    = st ? expect_wdata(kind, ea[1:0], d.rs2_value) : 32'h0;
        e.age      = next_age;
        e.rob_id   = next_rob;
        e.waiting  = 1'b0;
        e.wait_tag = '0;
        if (rand_below(3) == 0) begin
            while (tag_in_use(next_tag)) next_tag++;
            b.tag   = next_tag;
            b.delay = 8'(1 + rand_below(12));
            // the dispatched value is junk and only the broadcast carries the real one
            if (st && rand_below(2) == 0) begin
                b.value     = d.rs2_value;
                d.rs2_ready = 1'b0;
                d.rs2_tag   = next_tag;
                d.rs2_value = $random(seed);
            end else begin
                b.value     = base;
                d.rs1_ready = 1'b0;
                d.rs1_tag   = next_tag;
                d.rs1_value = $random(seed);
            end
            pending.push_back(b);
            e.waiting  = 1'b1;
            e.wait_tag = next_tag;
            next_tag++;
        end
        if (st) exp_stores.push_back(e);
        else exp_loads.push_back(e);
        next_age++;
        next_rob++;
    endtask

    task automatic run_cycle(input bit ld_ok, input bit st_ok, input int disp_pct,
                             input int busy_pct, input bit flush);
        lsu_pkg::ls_dispatch_t d;
        lsu_pkg::cdb_t         c;
        lsu_pkg::mem_state_e   ms;
        @(negedge clk);
        check_request();
        if (load_full) saw_load_full = 1'b1;
        if (store_full) saw_store_full = 1'b1;
        if (flush_check_wait != 0) begin
            flush_check_wait--;
            // the queues clear on the edge that ends the flush cycle
            if (flush_check_wait == 0) begin
                check_hex("load_full", load_full, 0);
                check_hex("store_full", store_full, 0);
            end
        end
        c = '0;
        foreach (pending[i]) begin
            if (pending[i].delay != 0) pending[i].delay--;
        end
        foreach (pending[i]) begin
            if (pending[i].delay == 0) begin
                c.valid = 1'b1;
                c.tag   = pending[i].tag;
                c.value = pending[i].value;
                clear_waiting(pending[i].tag);
                pending.delete(i);
                break;
            end
        end
        d = '0;
        // no back-to-back dispatch so the sampled full flag is never stale
        if (!flush && !disp_last && rand_below(100) < disp_pct) new_dispatch(ld_ok, st_ok, d);
        disp_last = d.valid;
        if (flush) begin
            ms = lsu_pkg::mem_busy;
        end else if (rand_below(100) < busy_pct) begin
            ms = rand_below(2) ? lsu_pkg::mem_busy : lsu_pkg::mem_done;
        end else begin
            ms = lsu_pkg::mem_idle;
        end
        @(posedge clk);
        dispatch          <= d;
        cdb               <= c;
        mem_state         <= ms;
        branch_mispredict <= flush;
        // the ROB head reaches the oldest store after a random commit delay
        if (exp_stores.size() != 0 && rand_below(2) != 0) rob_head <= exp_stores[0].rob_id;
        if (flush) begin
            exp_loads.delete();
            exp_stores.delete();
            pending.delete();
            flush_check_wait = 2;
        end
    endtask

    task automatic drain(input int busy_pct);
        int cycles;
        cycles = 0;
        while (exp_loads.size() != 0 || exp_stores.size() != 0 || pending.size() != 0) begin
            run_cycle(1'b0, 1'b0, 0, busy_pct, 1'b0);
            cycles++;
            if (cycles > 3000) begin
                $display("timeout: expected requests never reached the memory port");
                $display("RESULT: FAIL");
                $finish;
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        seed              = 32'h60da_d482;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        err_mark          = 0;
        next_age          = '0;
        next_rob          = '0;
        next_tag          = '0;
        disp_last         = 1'b0;
        saw_load_full     = 1'b0;
        saw_store_full    = 1'b0;
        flush_check_wait  = 0;
        rst               = 1'b1;
        dispatch          = '0;
        cdb               = '0;
        rob_head          = '0;
        mem_state         = lsu_pkg::mem_idle;
        branch_mispredict = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        repeat (300) run_cycle(1'b1, 1'b1, 60, 25, 1'b0);
        drain(25);
        end_test("random_mix");

        saw_load_full = 1'b0;
        repeat (40) run_cycle(1'b1, 1'b0, 100, 100, 1'b0);
        if (!saw_load_full) report_failure("load_full never rose while the memory was busy");
        drain(0);
        saw_store_full = 1'b0;
        repeat (40) run_cycle(1'b0, 1'b1, 100, 100, 1'b0);
        if (!saw_store_full) report_failure("store_full never rose while the memory was busy");
        drain(0);
        end_test("back_pressure");

        // memory held off so that at least one queue is full at the flush
        repeat (40) run_cycle(1'b1, 1'b1, 100, 100, 1'b0);
        run_cycle(1'b0, 1'b0, 0, 0, 1'b1);
        repeat (20) run_cycle(1'b0, 1'b0, 0, 0, 1'b0);
        repeat (60) run_cycle(1'b1, 1'b1, 60, 20, 1'b0);
        drain(20);
        end_test("flush");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit #(
    parameter int load_depth  = 8,
    parameter int store_depth = 8,
    parameter int tag_w       = lsu_pkg::TAG_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::ls_dispatch_t dispatch,
    input  lsu_pkg::cdb_t         cdb,
    input  logic [tag_w-1:0]      rob_head,
    input  lsu_pkg::mem_state_e   mem_state,
    input  logic                  branch_mispredict,
    output logic                  load_full,
    output logic                  store_full,
    output lsu_pkg::dmem_req_t    dmem
);

    lsu_pkg::lsq_entry_t   load_head;
    lsu_pkg::lsq_entry_t   store_head;
    lsu_pkg::store_probe_t store_probes [store_depth];
    lsu_pkg::store_probe_t store_st_probe;
    lsu_pkg::ls_station_t  load_st;
    lsu_pkg::ls_station_t  store_st;
    logic                  load_pop;
    logic                  store_pop;
    logic                  load_free;
    logic                  store_free;
    logic                  load_ready;
    logic                  load_taken;
    logic                  store_taken;

    operand_queue #(.depth(load_depth), .tag_w(tag_w), .holds_stores(1'b0)) load_q (
        .clk(clk), .rst(rst), .flush(branch_mispredict),
        .dispatch(dispatch), .cdb(cdb), .station_free(load_free),
        .full(load_full), .head(load_head), .pop(load_pop), .probes()
    );

    operand_queue #(.depth(store_depth), .tag_w(tag_w), .holds_stores(1'b1)) store_q (
        .clk(clk), .rst(rst), .flush(branch_mispredict),
        .dispatch(dispatch), .cdb(cdb), .station_free(store_free),
        .full(store_full), .head(store_head), .pop(store_pop), .probes(store_probes)
    );

    load_station #(.store_depth(store_depth)) load_rs (
        .clk(clk), .rst(rst), .flush(branch_mispredict),
        .in_entry(load_head), .load(load_pop),
        .store_probes(store_probes), .station_probe(store_st_probe),
        .taken(load_taken), .station(load_st),
        .ready_for_mem(load_ready), .free(load_free)
    );

    store_station store_rs (
        .clk(clk), .rst(rst), .flush(branch_mispredict),
        .in_entry(store_head), .load(store_pop), .taken(store_taken),
        .station(store_st), .probe(store_st_probe), .free(store_free)
    );

    mem_issue #(.tag_w(tag_w)) issuer (
        .load_st(load_st), .store_st(store_st), .load_ready(load_ready),
        .rob_head(rob_head), .mem_state(mem_state), .dmem(dmem),
        .load_taken(load_taken), .store_taken(store_taken)
    );

endmodule

//--- hw/mem_issue.sv
`timescale 1ns/1ps

module mem_issue #(
    parameter int tag_w = lsu_pkg::TAG_W
) (
    input  lsu_pkg::ls_station_t load_st,
    input  lsu_pkg::ls_station_t store_st,
    input  logic                 load_ready,
    input  logic [tag_w-1:0]     rob_head,
    input  lsu_pkg::mem_state_e  mem_state,
    output lsu_pkg::dmem_req_t   dmem,
    output logic                 load_taken,
    output logic                 store_taken
);

    logic idle;
    logic store_go;
    logic load_go;

    assign idle = (mem_state == lsu_pkg::mem_idle);

    // a store writes memory only once it is the oldest instruction in the ROB
    assign store_go = store_st.valid && (store_st.rob_id[tag_w-1:0] == rob_head) && idle;
    assign load_go  = !store_go && load_st.valid && load_ready && idle;

    assign store_taken = store_go;
    assign load_taken  = load_go;

    always_comb begin
        dmem = '0;
        if (store_go) begin
            dmem.addr  = {store_st.addr[lsu_pkg::XLEN-1:2], 2'b00};
            dmem.wmask = store_st.mask;
            dmem.wdata = store_st.wdata;
        end else if (load_go) begin
            dmem.addr  = {load_st.addr[lsu_pkg::XLEN-1:2], 2'b00};
            dmem.rmask = load_st.mask;
        end
    end

endmodule

//--- hw/store_station.sv
`timescale 1ns/1ps

module store_station (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  lsu_pkg::lsq_entry_t   in_entry,
    input  logic                  load,
    input  logic                  taken,
    output lsu_pkg::ls_station_t  station,
    output lsu_pkg::store_probe_t probe,
    output logic                  free
);

    logic [1:0]               lo;
    logic [lsu_pkg::XLEN-1:0] rs2;
    logic [lsu_pkg::XLEN-1:0] lane_data;

    assign lo  = in_entry.addr[1:0];
    assign rs2 = in_entry.inst.rs2_value;

    // rs2 moves into the addressed lanes and the rest stay zero
    always_comb begin
        lane_data = '0;
        case (in_entry.inst.op)
            lsu_pkg::sb: lane_data[8 * lo +: 8]       = rs2[7:0];
            lsu_pkg::sh: lane_data[16 * lo[1] +: 16]  = rs2[15:0];
            default:     lane_data                    = rs2;
        endcase
    end

    assign free = !station.valid;

    assign probe.valid      = station.valid;
    // only a store with a resolved address ever reaches here
    assign probe.addr_known = 1'b1;
    assign probe.age        = station.age;
    assign probe.word_addr  = station.addr[lsu_pkg::XLEN-1:2];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            station.valid <= 1'b0;
        end else if (taken) begin
            station.valid <= 1'b0;
        end else if (load) begin
            station.valid  <= 1'b1;
            station.op     <= in_entry.inst.op;
            station.addr   <= in_entry.addr;
            station.mask   <= lsu_pkg::access_mask(in_entry.inst.op, lo);
            station.wdata  <= lane_data;
            station.age    <= in_entry.inst.age;
            station.rob_id <= in_entry.inst.rob_id;
        end
    end

endmodule

//--- hw/load_station.sv
`timescale 1ns/1ps

module load_station #(
    parameter int store_depth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  lsu_pkg::lsq_entry_t   in_entry,
    input  logic                  load,
    input  lsu_pkg::store_probe_t store_probes [store_depth],
    input  lsu_pkg::store_probe_t station_probe,
    input  logic                  taken,
    output lsu_pkg::ls_station_t  station,
    output logic                  ready_for_mem,
    output logic                  free
);

    logic older_conflict;

    // an older store blocks the load while its word is unknown or the same
    function automatic logic blocks(input lsu_pkg::store_probe_t p,
                                    input lsu_pkg::ls_station_t ld);
        return p.valid && (p.age < ld.age)
               && (!p.addr_known || (p.word_addr == ld.addr[lsu_pkg::XLEN-1:2]));
    endfunction

    always_comb begin
        older_conflict = blocks(station_probe, station);
        for (int i = 0; i < store_depth; i++) begin
            older_conflict = older_conflict || blocks(store_probes[i], station);
        end
    end

    assign free = !station.valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            station.valid <= 1'b0;
            ready_for_mem <= 1'b0;
        end else if (taken) begin
            station.valid <= 1'b0;
            ready_for_mem <= 1'b0;
        end else if (load) begin
            station.valid  <= 1'b1;
            station.op     <= in_entry.inst.op;
            station.addr   <= in_entry.addr;
            station.mask   <= lsu_pkg::access_mask(in_entry.inst.op, in_entry.addr[1:0]);
            station.wdata  <= '0;
            station.age    <= in_entry.inst.age;
            station.rob_id <= in_entry.inst.rob_id;
            // first check runs on the captured entry next cycle
            ready_for_mem  <= 1'b0;
        end else begin
            ready_for_mem <= station.valid && !older_conflict;
        end
    end

endmodule

//--- hw/operand_queue.sv
`timescale 1ns/1ps

module operand_queue #(
    parameter int depth        = 8,
    parameter int tag_w        = lsu_pkg::TAG_W,
    parameter bit holds_stores = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  lsu_pkg::ls_dispatch_t dispatch,
    input  lsu_pkg::cdb_t         cdb,
    input  logic                  station_free,
    output logic                  full,
    output lsu_pkg::lsq_entry_t   head,
    output logic                  pop,
    output lsu_pkg::store_probe_t probes [depth]
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    lsu_pkg::lsq_entry_t entries [depth];
    lsu_pkg::lsq_entry_t incoming;
    logic [idx_w-1:0]    front;
    logic [idx_w-1:0]    rear;
    logic [cnt_w-1:0]    count;
    logic                empty;
    logic                push;
    logic                head_ready;

    function automatic logic [idx_w-1:0] next_idx(input logic [idx_w-1:0] idx);
        return (idx == idx_w'(depth - 1)) ? '0 : idx + 1'b1;
    endfunction

    // broadcast result for a source that is still waiting
    function automatic logic hits(input lsu_pkg::cdb_t bc,
                                  input logic [tag_w-1:0] tag,
                                  input logic ready);
        return bc.valid && !ready && (tag == bc.tag[tag_w-1:0]);
    endfunction

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));
    assign push  = dispatch.valid && (dispatch.is_store == holds_stores) && !full;
    assign head  = entries[front];

    // loads never wait on rs2
    assign head_ready = !empty && head.inst.rs1_ready && head.addr_known
                        && (head.inst.rs2_ready || !holds_stores);
    assign pop = head_ready && station_free;

    // a tag broadcast in the dispatch cycle must not be missed
    always_comb begin
        incoming      = '0;
        incoming.inst = dispatch;
        if (hits(cdb, dispatch.rs1_tag[tag_w-1:0], dispatch.rs1_ready)) begin
            incoming.inst.rs1_ready = 1'b1;
            incoming.inst.rs1_value = cdb.value;
        end
        if (hits(cdb, dispatch.rs2_tag[tag_w-1:0], dispatch.rs2_ready)) begin
            incoming.inst.rs2_ready = 1'b1;
            incoming.inst.rs2_value = cdb.value;
        end
    end

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            probes[i].valid      = entries[i].inst.valid;
            probes[i].addr_known = entries[i].addr_known;
            probes[i].age        = entries[i].inst.age;
            probes[i].word_addr  = entries[i].addr[lsu_pkg::XLEN-1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            rear  <= '0;
            count <= '0;
            for (int i = 0; i < depth; i++) begin
                entries[i].inst.valid <= 1'b0;
                entries[i].addr_known <= 1'b0;
            end
        end else begin
            for (int i = 0; i < depth; i++) begin
                if (entries[i].inst.valid) begin
                    if (hits(cdb, entries[i].inst.rs1_tag[tag_w-1:0],
                             entries[i].inst.rs1_ready)) begin
                        entries[i].inst.rs1_ready <= 1'b1;
                        entries[i].inst.rs1_value <= cdb.value;
                    end
                    if (hits(cdb, entries[i].inst.rs2_tag[tag_w-1:0],
                             entries[i].inst.rs2_ready)) begin
                        entries[i].inst.rs2_ready <= 1'b1;
                        entries[i].inst.rs2_value <= cdb.value;
                    end
                    // address follows one edge after the base is known
                    if (entries[i].inst.rs1_ready && !entries[i].addr_known) begin
                        entries[i].addr       <= entries[i].inst.rs1_value + entries[i].inst.imm;
                        entries[i].addr_known <= 1'b1;
                    end
                end
            end
            if (pop) begin
                entries[front].inst.valid <= 1'b0;
                front                     <= next_idx(front);
            end
            if (push) begin
                entries[rear] <= incoming;
                rear          <= next_idx(rear);
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

endmodule

//--- hw/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN  = 32;
    localparam int TAG_W = 5;
    // program-order age where a lower value is older
    localparam int AGE_W = 16;

    // low three bits hold funct3 and bit 3 marks a store
    typedef enum logic [3:0] {
        lb  = 4'b0000,
        lh  = 4'b0001,
        lw  = 4'b0010,
        lbu = 4'b0100,
        lhu = 4'b0101,
        sb  = 4'b1000,
        sh  = 4'b1001,
        sw  = 4'b1010
    } mem_op_e;

    typedef enum logic [1:0] {
        mem_idle = 2'd0,
        mem_busy = 2'd1,
        mem_done = 2'd2
    } mem_state_e;

    typedef struct packed {
        logic             valid;
        logic             is_store;
        mem_op_e          op;
        logic [TAG_W-1:0] rs1_tag;
        logic             rs1_ready;
        logic [XLEN-1:0]  rs1_value;
        logic [TAG_W-1:0] rs2_tag;
        logic             rs2_ready;
        logic [XLEN-1:0]  rs2_value;
        logic [XLEN-1:0]  imm;
        logic [AGE_W-1:0] age;
        logic [TAG_W-1:0] rob_id;
    } ls_dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } cdb_t;

    typedef struct packed {
        ls_dispatch_t    inst;
        logic [XLEN-1:0] addr;
        logic            addr_known;
    } lsq_entry_t;

    typedef struct packed {
        logic             valid;
        logic             addr_known;
        logic [AGE_W-1:0] age;
        logic [XLEN-3:0]  word_addr;
    } store_probe_t;

    typedef struct packed {
        logic             valid;
        mem_op_e          op;
        logic [XLEN-1:0]  addr;
        logic [3:0]       mask;
        logic [XLEN-1:0]  wdata;
        logic [AGE_W-1:0] age;
        logic [TAG_W-1:0] rob_id;
    } ls_station_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [3:0]      rmask;
        logic [3:0]      wmask;
        logic [XLEN-1:0] wdata;
    } dmem_req_t;

    // byte lanes touched by an access for both reads and writes
    function automatic logic [3:0] access_mask(input mem_op_e op, input logic [1:0] lo);
        case (op)
            lb, lbu, sb: return 4'b0001 << lo;
            lh, lhu, sh: return 4'b0011 << lo;
            default:     return 4'b1111;
        endcase
    endfunction

endpackage
